/* verilog/rv_isa_pkg.sv */
// RV32 data widths, opcodes, funct3 and funct7 codes, instruction word union
package rv_isa_pkg;

  // Data path and register address widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Opcodes kept by the integer pipeline
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_e;

  // funct3 per ALU function, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Selects sub and sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  ////////////////////////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_type_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } u_type_t;

  // One fetched word, viewed through the format its opcode picks
  typedef union packed {
    r_type_t r;
    i_type_t i;
    u_type_t u;
  } instr_word_u;

endpackage

/* verilog/rv_pipe_pkg.sv */
// ALU operation encoding and the records passed between pipeline stages
package rv_pipe_pkg;

  // ALU operations, PASS_B serves lui
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // Accepted input word
  typedef struct packed {
    rv_isa_pkg::instr_word_u word;
  } instr_in_t;

  // Operands already resolved in ID
  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0]       op_a;
    logic [rv_isa_pkg::XLEN-1:0]       op_b;
    alu_op_e                           alu_op;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic                              we;
    logic                              illegal;
  } id_ex_t;

  // Finished instruction, also the retire record
  typedef struct packed {
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]       result;
    logic                              we;
    logic                              illegal;
  } ex_wb_t;

  typedef ex_wb_t retire_t;

  // One forwarding source as seen by ID
  typedef struct packed {
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]       value;
    logic                              valid;
  } fwd_t;

endpackage

/* verilog/rv_register_file.sv */
// Integer register file, two combinational read ports, one write port
`timescale 1ns/1ns

module rv_register_file #(
  parameter int RF_NUM_REGS = 32
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  // Read ports
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_isa_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_isa_pkg::XLEN-1:0]       rdata_b_o,
  // Write port
  input  logic                              we_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       wdata_i
);
  import rv_isa_pkg::*;

  localparam int AW = $clog2(RF_NUM_REGS);

  logic [XLEN-1:0] regs [RF_NUM_REGS];

  // x0 and out-of-range indices read as zero
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
    if (addr == '0 || addr >= RF_NUM_REGS) return '0;
    return regs[addr[AW-1:0]];
  endfunction

  always_comb begin
    rdata_a_o = read_port(raddr_a_i);
    rdata_b_o = read_port(raddr_b_i);
  end

  // x0 never written
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      regs <= '{default: '0};
    end else if (we_i && waddr_i != '0 && waddr_i < RF_NUM_REGS) begin
      regs[waddr_i[AW-1:0]] <= wdata_i;
    end
  end

endmodule

/* verilog/rv_id_stage.sv */
// Decode stage: instruction accept, decode, forwarded operands and ID/EX register
`timescale 1ns/1ns

module rv_id_stage #(
  parameter int RF_NUM_REGS = 32
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  // Instruction input
  input  rv_pipe_pkg::instr_in_t            instr_i,
  input  logic                              instr_valid_i,
  output logic                              instr_ready_o,
  // Register file read side
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [rv_isa_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       rf_rdata_b_i,
  // Forwarding from EX and WB
  input  rv_pipe_pkg::fwd_t                 ex_fwd_i,
  input  rv_pipe_pkg::fwd_t                 wb_fwd_i,
  // ID/EX pipeline
  output rv_pipe_pkg::id_ex_t               id_ex_o,
  output logic                              id_ex_valid_o,
  input  logic                              ex_ready_i
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  // Operand B source
  typedef enum logic [1:0] {
    OPB_REG,
    OPB_IMM,
    OPB_SHAMT,
    OPB_UPPER
  } opb_src_e;

  instr_word_u     iw;
  alu_op_e         alu_op;
  opb_src_e        opb_src;
  logic            uses_rs2;
  logic            is_shift;
  logic            bad_funct;
  logic            bad_reg;
  logic            illegal;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  id_ex_t          id_ex_d;

  // Same funct3 map for OP and OP_IMM
  function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Youngest writer wins, x0 always zero
  function automatic logic [XLEN-1:0] fwd_pick(input logic [REG_ADDR_W-1:0] addr,
                                               input logic [XLEN-1:0]       rf_val,
                                               input fwd_t                  ex_src,
                                               input fwd_t                  wb_src);
    if (addr == '0) return '0;
    if (ex_src.valid && ex_src.rd == addr) return ex_src.value;
    if (wb_src.valid && wb_src.rd == addr) return wb_src.value;
    return rf_val;
  endfunction

  assign iw = instr_i.word;

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Shift immediates carry funct7 in imm[11:5]
    is_shift  = (iw.i.funct3 == F3_SLL) || (iw.i.funct3 == F3_SR);
    alu_op    = ALU_ADD;
    opb_src   = OPB_REG;
    uses_rs2  = 1'b0;
    bad_funct = 1'b0;
    case (iw.r.opcode)
      OP: begin
        uses_rs2  = 1'b1;
        alu_op    = f3_to_op(iw.r.funct3, iw.r.funct7 == FUNCT7_ALT);
        bad_funct = (iw.r.funct7 != '0) &&
                    !(iw.r.funct7 == FUNCT7_ALT &&
                      (iw.r.funct3 == F3_ADD || iw.r.funct3 == F3_SR));
      end
      OP_IMM: begin
        alu_op    = f3_to_op(iw.i.funct3, is_shift && iw.r.funct7 == FUNCT7_ALT);
        opb_src   = is_shift ? OPB_SHAMT : OPB_IMM;
        bad_funct = is_shift && (iw.r.funct7 != '0) &&
                    !(iw.r.funct7 == FUNCT7_ALT && iw.i.funct3 == F3_SR);
      end
      LUI: begin
        alu_op  = ALU_PASS_B;
        opb_src = OPB_UPPER;
      end
      default: begin
        bad_funct = 1'b1;
      end
    endcase
  end

  // Registers beyond RV32E range, rs1 field is immediate for lui
  assign bad_reg = (iw.r.rd >= RF_NUM_REGS) ||
                   (iw.r.opcode != LUI && iw.r.rs1 >= RF_NUM_REGS) ||
                   (uses_rs2 && iw.r.rs2 >= RF_NUM_REGS);
  assign illegal = bad_funct || bad_reg;

  ////////////////////////////////////////////////////////////
  // Operands
  ////////////////////////////////////////////////////////////

  assign rf_raddr_a_o = iw.r.rs1;
  assign rf_raddr_b_o = iw.r.rs2;

  // EX first, then WB, then register file
  assign rs1_val = fwd_pick(iw.r.rs1, rf_rdata_a_i, ex_fwd_i, wb_fwd_i);
  assign rs2_val = fwd_pick(iw.r.rs2, rf_rdata_b_i, ex_fwd_i, wb_fwd_i);

  always_comb begin
    id_ex_d.op_a = rs1_val;
    case (opb_src)
      OPB_IMM:   id_ex_d.op_b = {{(XLEN-12){iw.i.imm[11]}}, iw.i.imm};
      OPB_SHAMT: id_ex_d.op_b = {{(XLEN-REG_ADDR_W){1'b0}}, iw.r.rs2};
      OPB_UPPER: id_ex_d.op_b = {iw.u.imm, 12'h000};
      default:   id_ex_d.op_b = rs2_val;
    endcase
    id_ex_d.alu_op  = alu_op;
    id_ex_d.rd      = iw.r.rd;
    // Illegal never writes
    id_ex_d.we      = !illegal;
    id_ex_d.illegal = illegal;
  end

  ////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////

  // Empty or draining this cycle
  assign instr_ready_o = !id_ex_valid_o || ex_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_ex_valid_o <= 1'b0;
    end else if (instr_ready_o) begin
      id_ex_valid_o <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

/* verilog/rv_ex_stage.sv */
// Execute stage: ALU, EX forwarding source and EX/WB register
`timescale 1ns/1ns

module rv_ex_stage (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // ID/EX pipeline
  input  rv_pipe_pkg::id_ex_t id_ex_i,
  input  logic                id_ex_valid_i,
  output logic                ex_ready_o,
  // Forwarding to ID
  output rv_pipe_pkg::fwd_t   ex_fwd_o,
  // EX/WB pipeline
  output rv_pipe_pkg::ex_wb_t ex_wb_o,
  output logic                ex_wb_valid_o,
  input  logic                wb_ready_i
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [SHW-1:0]  shamt;
  logic [XLEN-1:0] result;

  assign op_a  = id_ex_i.op_a;
  assign op_b  = id_ex_i.op_b;
  // Low bits only, as RV32 shifts define
  assign shamt = op_b[SHW-1:0];

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      // Sign fill
      ALU_SRA:    result = $signed(op_a) >>> shamt;
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

  // Result of the instruction held in ID/EX
  assign ex_fwd_o.rd    = id_ex_i.rd;
  assign ex_fwd_o.value = result;
  assign ex_fwd_o.valid = id_ex_valid_i && id_ex_i.we;

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  assign ex_ready_o = !ex_wb_valid_o || wb_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_wb_valid_o <= 1'b0;
    end else if (ex_ready_o) begin
      ex_wb_valid_o <= id_ex_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_ex_valid_i && ex_ready_o) begin
      ex_wb_o.rd      <= id_ex_i.rd;
      ex_wb_o.result  <= result;
      ex_wb_o.we      <= id_ex_i.we;
      ex_wb_o.illegal <= id_ex_i.illegal;
    end
  end

endmodule

/* verilog/rv_wb_stage.sv */
// Write-back stage: retire handshake, register file write, WB forwarding source
`timescale 1ns/1ns

module rv_wb_stage (
  // EX/WB pipeline
  input  rv_pipe_pkg::ex_wb_t               ex_wb_i,
  input  logic                              ex_wb_valid_i,
  output logic                              wb_ready_o,
  // Forwarding to ID
  output rv_pipe_pkg::fwd_t                 wb_fwd_o,
  // Register file write port
  output logic                              rf_we_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [rv_isa_pkg::XLEN-1:0]       rf_wdata_o,
  // Retire port
  output rv_pipe_pkg::retire_t              retire_o,
  output logic                              retire_valid_o,
  input  logic                              retire_ready_i
);

  logic retire_xfer;
  logic commit;

  // Record sits in EX/WB until the retire port takes it
  assign retire_o       = ex_wb_i;
  assign retire_valid_o = ex_wb_valid_i;
  assign wb_ready_o     = retire_ready_i || !ex_wb_valid_i;

  assign retire_xfer = ex_wb_valid_i && retire_ready_i;

  // Only legal writers touch state
  assign commit = ex_wb_i.we && !ex_wb_i.illegal;

  // Write lands on the retire edge
  assign rf_we_o    = retire_xfer && commit;
  assign rf_waddr_o = ex_wb_i.rd;
  assign rf_wdata_o = ex_wb_i.result;

  // Valid until retire, covers the RF write latency
  assign wb_fwd_o.rd    = ex_wb_i.rd;
  assign wb_fwd_o.value = ex_wb_i.result;
  assign wb_fwd_o.valid = ex_wb_valid_i && commit;

endmodule

/* verilog/rv_int_core.sv */
// Integer pipeline top: decode, execute, write-back stages and register file
`timescale 1ns/1ns

module rv_int_core #(
  parameter int RF_NUM_REGS = 32
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Instruction input
  input  rv_pipe_pkg::instr_in_t instr_i,
  input  logic                   instr_valid_i,
  output logic                   instr_ready_o,
  // Retire output
  output rv_pipe_pkg::retire_t   retire_o,
  output logic                   retire_valid_o,
  input  logic                   retire_ready_i
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  // ID/EX pipeline
  id_ex_t                id_ex;
  logic                  id_ex_valid;
  logic                  ex_ready;

  // EX/WB pipeline
  ex_wb_t                ex_wb;
  logic                  ex_wb_valid;
  logic                  wb_ready;

  // Forwarding sources
  fwd_t                  ex_fwd;
  fwd_t                  wb_fwd;

  // Register file ports
  logic [REG_ADDR_W-1:0] rf_raddr_a;
  logic [REG_ADDR_W-1:0] rf_raddr_b;
  logic [XLEN-1:0]       rf_rdata_a;
  logic [XLEN-1:0]       rf_rdata_b;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  rv_id_stage #(
    .RF_NUM_REGS   ( RF_NUM_REGS   )
  ) id_stage_i (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .instr_i       ( instr_i       ),
    .instr_valid_i ( instr_valid_i ),
    .instr_ready_o ( instr_ready_o ),
    .rf_raddr_a_o  ( rf_raddr_a    ),
    .rf_raddr_b_o  ( rf_raddr_b    ),
    .rf_rdata_a_i  ( rf_rdata_a    ),
    .rf_rdata_b_i  ( rf_rdata_b    ),
    .ex_fwd_i      ( ex_fwd        ),
    .wb_fwd_i      ( wb_fwd        ),
    .id_ex_o       ( id_ex         ),
    .id_ex_valid_o ( id_ex_valid   ),
    .ex_ready_i    ( ex_ready      )
  );

  rv_register_file #(
    .RF_NUM_REGS ( RF_NUM_REGS )
  ) register_file_i (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .raddr_a_i   ( rf_raddr_a  ),
    .raddr_b_i   ( rf_raddr_b  ),
    .rdata_a_o   ( rf_rdata_a  ),
    .rdata_b_o   ( rf_rdata_b  ),
    .we_i        ( rf_we       ),
    .waddr_i     ( rf_waddr    ),
    .wdata_i     ( rf_wdata    )
  );

  ////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////

  rv_ex_stage ex_stage_i (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .id_ex_i       ( id_ex       ),
    .id_ex_valid_i ( id_ex_valid ),
    .ex_ready_o    ( ex_ready    ),
    .ex_fwd_o      ( ex_fwd      ),
    .ex_wb_o       ( ex_wb       ),
    .ex_wb_valid_o ( ex_wb_valid ),
    .wb_ready_i    ( wb_ready    )
  );

  ////////////////////////////////////////////////////////////
  // Write-back
  ////////////////////////////////////////////////////////////

  rv_wb_stage wb_stage_i (
    .ex_wb_i        ( ex_wb          ),
    .ex_wb_valid_i  ( ex_wb_valid    ),
    .wb_ready_o     ( wb_ready       ),
    .wb_fwd_o       ( wb_fwd         ),
    .rf_we_o        ( rf_we          ),
    .rf_waddr_o     ( rf_waddr       ),
    .rf_wdata_o     ( rf_wdata       ),
    .retire_o       ( retire_o       ),
    .retire_valid_o ( retire_valid_o ),
    .retire_ready_i ( retire_ready_i )
  );

endmodule

/* include/tb_rv_model.svh */
// LFSR step, instruction encoders and ALU reference model for the testbench
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] fib_step(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// Register-register op
function automatic rv_isa_pkg::instr_word_u enc_r(input logic [6:0] f7,
                                                  input logic [4:0] rs2,
                                                  input logic [4:0] rs1,
                                                  input logic [2:0] f3,
                                                  input logic [4:0] rd);
  rv_isa_pkg::instr_word_u w;
  w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: rv_isa_pkg::OP};
  return w;
endfunction

// Register-immediate op, shifts put funct7 in imm[11:5]
function automatic rv_isa_pkg::instr_word_u enc_i(input logic [11:0] imm,
                                                  input logic [4:0]  rs1,
                                                  input logic [2:0]  f3,
                                                  input logic [4:0]  rd);
  rv_isa_pkg::instr_word_u w;
  w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: rv_isa_pkg::OP_IMM};
  return w;
endfunction

function automatic rv_isa_pkg::instr_word_u enc_lui(input logic [19:0] imm,
                                                    input logic [4:0]  rd);
  rv_isa_pkg::instr_word_u w;
  w.u = '{imm: imm, rd: rd, opcode: rv_isa_pkg::LUI};
  return w;
endfunction

// Expected result from raw operand values
function automatic logic [31:0] ref_result(input rv_isa_pkg::instr_word_u w,
                                           input logic [31:0]             a,
                                           input logic [31:0]             b_reg);
  logic [31:0] b;
  logic        alt;
  logic        is_op;
  is_op = (w.r.opcode == rv_isa_pkg::OP);
  b     = is_op ? b_reg : {{20{w.i.imm[11]}}, w.i.imm};
  alt   = (w.r.funct7 == rv_isa_pkg::FUNCT7_ALT);
  if (w.u.opcode == rv_isa_pkg::LUI) return {w.u.imm, 12'h000};
  case (w.r.funct3)
    rv_isa_pkg::F3_ADD:  return (is_op && alt) ? a - b : a + b;
    rv_isa_pkg::F3_SLL:  return a << b[4:0];
    rv_isa_pkg::F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
    rv_isa_pkg::F3_SLTU: return {31'b0, a < b};
    rv_isa_pkg::F3_XOR:  return a ^ b;
    rv_isa_pkg::F3_SR: begin
      if (alt) return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    rv_isa_pkg::F3_OR:   return a | b;
    default:             return a & b;
  endcase
endfunction

`endif

/* tb/tb_rv_int_core.sv */
// Testbench for the integer pipeline: stimulus, shadow register file, assertions, report
`timescale 1ns/1ns

module tb_rv_int_core;
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  `include "tb_rv_model.svh"

  logic        clk_i;
  logic        arst_n_i;
  instr_in_t   instr_i;
  logic        instr_valid_i;
  logic        instr_ready_o;
  retire_t     retire_o;
  logic        retire_valid_o;
  logic        retire_ready_i;

  // Expected retire records in accept order
  retire_t     exp_mem [64];
  logic [5:0]  head = '0;
  logic [5:0]  tail = '0;
  logic [31:0] shadow [16];
  logic        seen_accept = 1'b0;
  logic        bp_on = 1'b0;
  logic        retire_xfer;
  logic [15:0] data_lfsr = 16'd13;
  logic [15:0] bp_lfsr = 16'd13;
  int          errors = 0;
  int          tests = 0;
  int          test_start_errors = 0;

  rv_int_core #(
    .RF_NUM_REGS    ( 16             )
  ) uut (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .instr_i        ( instr_i        ),
    .instr_valid_i  ( instr_valid_i  ),
    .instr_ready_o  ( instr_ready_o  ),
    .retire_o       ( retire_o       ),
    .retire_valid_o ( retire_valid_o ),
    .retire_ready_i ( retire_ready_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // One LFSR step per bit
  task automatic draw_bits(input int n, output logic [31:0] v);
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      data_lfsr = fib_step(data_lfsr);
      v = {v[30:0], data_lfsr[0]};
    end
  endtask

  // x0 and missing RV32E registers read zero
  function automatic logic [31:0] reg_value(input logic [4:0] idx);
    if (idx == 5'd0 || idx >= 5'd16) return '0;
    return shadow[idx[3:0]];
  endfunction

  // RV32I/E legality for the kept opcodes
  function automatic logic decode_illegal(input instr_word_u w);
    logic shift;
    shift = (w.i.funct3 == F3_SLL) || (w.i.funct3 == F3_SR);
    case (w.r.opcode)
      OP: return (w.r.funct7 != 7'h00 &&
                  !(w.r.funct7 == FUNCT7_ALT &&
                    (w.r.funct3 == F3_ADD || w.r.funct3 == F3_SR))) ||
                 w.r.rd >= 5'd16 || w.r.rs1 >= 5'd16 || w.r.rs2 >= 5'd16;
      OP_IMM: return (shift && w.r.funct7 != 7'h00 &&
                      !(w.r.funct7 == FUNCT7_ALT && w.i.funct3 == F3_SR)) ||
                     w.r.rd >= 5'd16 || w.r.rs1 >= 5'd16;
      LUI: return w.u.rd >= 5'd16;
      default: return 1'b1;
    endcase
  endfunction

  // Result bits carry no meaning on illegal records
  function automatic retire_t mask_result(input retire_t r);
    retire_t m;
    m = r;
    if (m.illegal) m.result = '0;
    return m;
  endfunction

  // Stuck handshake or drain
  task automatic timeout_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // Hand one word over, then log its expected record
  task automatic send(input instr_word_u w);
    int      waited;
    retire_t rec;
    instr_i.word  <= w;
    instr_valid_i <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!instr_ready_o && waited < 100);
    if (!instr_ready_o) begin
      timeout_error("Timeout: instr_ready_o stayed low for 100 cycles");
    end else begin
      seen_accept  = 1'b1;
      rec.rd       = w.r.rd;
      rec.illegal  = decode_illegal(w);
      rec.we       = !rec.illegal;
      rec.result   = ref_result(w, reg_value(w.r.rs1), reg_value(w.r.rs2));
      exp_mem[tail] = rec;
      tail = tail + 1'b1;
      if (rec.we && w.r.rd != 5'd0) shadow[w.r.rd[3:0]] = rec.result;
    end
  endtask

  // Random legal ALU operation
  task automatic random_op(output instr_word_u w);
    logic [31:0] v;
    logic        is_imm;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    draw_bits(1, v);
    is_imm = v[0];
    draw_bits(3, v);
    f3 = v[2:0];
    draw_bits(1, v);
    alt = v[0];
    draw_bits(12, v);
    rd  = {1'b0, v[3:0]};
    rs1 = {1'b0, v[7:4]};
    rs2 = {1'b0, v[11:8]};
    draw_bits(12, v);
    if (!is_imm)
      w = enc_r((alt && (f3 == F3_ADD || f3 == F3_SR)) ? FUNCT7_ALT : 7'h00, rs2, rs1, f3, rd);
    else if (f3 == F3_SLL)
      w = enc_i({7'h00, v[4:0]}, rs1, f3, rd);
    else if (f3 == F3_SR)
      w = enc_i({alt ? FUNCT7_ALT : 7'h00, v[4:0]}, rs1, f3, rd);
    else
      w = enc_i(v[11:0], rs1, f3, rd);
  endtask

  // Random sources x1..x4 into x5..x12
  task automatic rr_random(input logic [6:0] f7, input logic [2:0] f3);
    logic [31:0] v;
    draw_bits(7, v);
    send(enc_r(f7, {3'b0, v[1:0]} + 5'd1, {3'b0, v[3:2]} + 5'd1, f3, {2'b0, v[6:4]} + 5'd5));
  endtask

  task automatic drain(input int limit);
    int waited;
    instr_valid_i <= 1'b0;
    waited = 0;
    while (head != tail && waited < limit) begin
      @(posedge clk_i);
      waited++;
    end
    if (head != tail) timeout_error("Timeout: outstanding instructions never retired");
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %0d %-12s %s", tests, name,
             (errors == test_start_errors) ? "passed" : "failed");
    test_start_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Retire side
  ////////////////////////////////////////////////////////////

  assign retire_xfer = retire_valid_o && retire_ready_i;

  always @(posedge clk_i) begin
    if (retire_xfer) head <= head + 1'b1;
    if (bp_on) begin
      bp_lfsr = fib_step(bp_lfsr);
      retire_ready_i <= bp_lfsr[0];
    end else begin
      retire_ready_i <= 1'b1;
    end
  end

  // Idle until the first accept
  quiet_until_accept: assert property (@(posedge clk_i) !seen_accept |-> !retire_valid_o)
    else begin
      errors++;
      $display("FAILED retire_valid_o: got %h, expected 0", $sampled(retire_valid_o));
    end

  ready_after_reset: assert property (@(posedge clk_i) $rose(arst_n_i) |-> instr_ready_o)
    else begin
      errors++;
      $display("FAILED instr_ready_o: got %h, expected 1", $sampled(instr_ready_o));
    end

  no_extra_retire: assert property (@(posedge clk_i) retire_xfer |-> head != tail)
    else begin
      errors++;
      $display("A record retired with no instruction outstanding");
    end

  // Same order, same rd, result, flags
  record_matches: assert property (@(posedge clk_i) retire_xfer && head != tail |->
                                   mask_result(retire_o) == mask_result(exp_mem[head]))
    else begin
      errors++;
      $display("FAILED retire_o: got %h, expected %h",
               $sampled(retire_o), $sampled(exp_mem[head]));
    end

  held_while_stalled: assert property (@(posedge clk_i) retire_valid_o && !retire_ready_i |=>
                                       retire_valid_o && $stable(retire_o))
    else begin
      errors++;
      $display("FAILED retire_o: dropped or changed while stalled, now %h",
               $sampled(retire_o));
    end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] v;
    instr_word_u w;
    int          k;
    arst_n_i       = 1'b0;
    instr_i        = '0;
    instr_valid_i  = 1'b0;
    retire_ready_i = 1'b1;
    shadow         = '{default: '0};
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    report_test("reset");

    // Load x1..x4, then all ten register ops
    for (k = 1; k <= 4; k++) begin
      draw_bits(32, v);
      send(enc_lui(v[31:12], k[4:0]));
      send(enc_i(v[11:0], k[4:0], F3_ADD, k[4:0]));
    end
    rr_random(7'h00, F3_ADD);
    rr_random(FUNCT7_ALT, F3_ADD);
    rr_random(7'h00, F3_SLL);
    rr_random(7'h00, F3_SLT);
    rr_random(7'h00, F3_SLTU);
    rr_random(7'h00, F3_XOR);
    rr_random(7'h00, F3_SR);
    rr_random(FUNCT7_ALT, F3_SR);
    rr_random(7'h00, F3_OR);
    rr_random(7'h00, F3_AND);
    drain(50);
    report_test("reg-reg");

    // Edge immediates
    send(enc_i(12'hfff, 5'd1, F3_ADD, 5'd5));
    send(enc_i(12'h800, 5'd2, F3_ADD, 5'd6));
    send(enc_i(12'h000, 5'd3, F3_SLL, 5'd7));
    send(enc_i(12'h01f, 5'd3, F3_SLL, 5'd8));
    send(enc_i(12'h01f, 5'd4, F3_SR, 5'd9));
    send(enc_i(12'h41f, 5'd4, F3_SR, 5'd10));
    send(enc_i(12'h400, 5'd4, F3_SR, 5'd11));
    send(enc_i(12'hf00, 5'd1, F3_SLT, 5'd12));
    send(enc_i(12'hfff, 5'd2, F3_SLTU, 5'd13));
    send(enc_i(12'h9a5, 5'd3, F3_XOR, 5'd14));
    send(enc_i(12'hc3c, 5'd3, F3_OR, 5'd15));
    send(enc_i(12'h8f0, 5'd4, F3_AND, 5'd5));
    send(enc_lui(20'hfedcb, 5'd6));
    drain(50);
    report_test("immediate");

    // Distances 1, 2 and 3
    send(enc_i(12'h123, 5'd1, F3_ADD, 5'd5));
    send(enc_r(7'h00, 5'd5, 5'd5, F3_ADD, 5'd6));
    send(enc_r(FUNCT7_ALT, 5'd5, 5'd6, F3_ADD, 5'd7));
    send(enc_r(7'h00, 5'd7, 5'd5, F3_XOR, 5'd8));
    send(enc_r(7'h00, 5'd6, 5'd8, F3_SLL, 5'd8));
    send(enc_i(12'h7ff, 5'd8, F3_ADD, 5'd8));
    drain(50);
    report_test("forwarding");

    bp_on <= 1'b1;
    for (k = 0; k < 32; k++) begin
      random_op(w);
      send(w);
    end
    drain(400);
    bp_on <= 1'b0;
    report_test("backpressure");

    // Unknown opcode on rd x5, then index 20 as rd and rs2
    send(instr_word_u'(32'h0000_02ff));
    send(enc_i(12'h007, 5'd1, F3_ADD, 5'd20));
    send(enc_r(7'h00, 5'd20, 5'd1, F3_ADD, 5'd7));
    send(enc_i(12'h000, 5'd5, F3_ADD, 5'd9));
    send(enc_i(12'h000, 5'd7, F3_ADD, 5'd10));
    drain(50);
    report_test("illegal");

    $display("tests run %0d, failing checks %0d", tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* rv_int_core.f */
+incdir+include
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/rv_register_file.sv
verilog/rv_id_stage.sv
verilog/rv_ex_stage.sv
verilog/rv_wb_stage.sv
verilog/rv_int_core.sv
tb/tb_rv_int_core.sv

/* Bender.yml */
package:
  name: rv_int_core

sources:
  - verilog/rv_isa_pkg.sv
  - verilog/rv_pipe_pkg.sv
  - verilog/rv_register_file.sv
  - verilog/rv_id_stage.sv
  - verilog/rv_ex_stage.sv
  - verilog/rv_wb_stage.sv
  - verilog/rv_int_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_rv_int_core.sv
